/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cp0
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
hdl/cp0_pkg.sv
hdl/cp0_cmd_decode.sv
hdl/cp0_timer.sv
hdl/cp0_exc_regs.sv
hdl/cp0_read_mux.sv
hdl/cp0_top.sv
verif/cp0_checker.sv
verif/tb_cp0.sv

/* hdl/cp0_cmd_decode.sv */
`timescale 1ns/1ns

module cp0_cmd_decode import cp0_pkg::*; (
    input  logic       m1s_valid,
    input  logic       m1s_inst_mtc0,
    input  logic       m1s_inst_eret,
    input  logic       m1s_ex,        // Memory stage carries an exception
    input  logic [4:0] m1s_rd,
    input  logic [2:0] m1s_sel,
    input  exc_type_t  m1s_exc_type,
    output cp0_addr_t  addr,
    output logic       count_we,
    output logic       compare_we,
    output logic       status_we,
    output logic       cause_we,
    output logic       epc_we,
    output logic       eret_flush,
    output exc_code_t  exc_code
);

    logic mtc0_we;  // Qualified mtc0

    assign addr = {m1s_rd, m1s_sel};  // Same address for mfc0 and mtc0

    // An excepting instruction must not commit its write
    assign mtc0_we = m1s_valid && m1s_inst_mtc0 && !m1s_ex;

    assign count_we   = mtc0_we && (addr == ADDR_COUNT);
    assign compare_we = mtc0_we && (addr == ADDR_COMPARE);
    assign status_we  = mtc0_we && (addr == ADDR_STATUS);
    assign cause_we   = mtc0_we && (addr == ADDR_CAUSE);
    assign epc_we     = mtc0_we && (addr == ADDR_EPC);

    assign eret_flush = m1s_valid && m1s_inst_eret && !m1s_ex;  // Flush in the eret cycle

    // Pipeline type to architectural code
    always_comb begin
        case (m1s_exc_type)
            EXC_INT:  exc_code = CODE_INT;
            EXC_ADEL: exc_code = CODE_ADEL;
            EXC_ADES: exc_code = CODE_ADES;
            EXC_SYS:  exc_code = CODE_SYS;
            EXC_BP:   exc_code = CODE_BP;
            EXC_RI:   exc_code = CODE_RI;
            EXC_OV:   exc_code = CODE_OV;
            default:  exc_code = CODE_INT;  // Unused encodings
        endcase
    end

    // One register write or one eret per instruction, never a mix
    always_comb begin
        assert ($onehot0({count_we, compare_we, status_we, cause_we, epc_we, eret_flush}))
            else $error("cp0_cmd_decode: more than one write strobe or flush active");
    end

endmodule

/* hdl/cp0_exc_regs.sv */
`timescale 1ns/1ns

module cp0_exc_regs import cp0_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            status_we,
    input  logic            cause_we,
    input  logic            epc_we,
    input  logic            eret_flush,
    input  logic [XLEN-1:0] wdata,
    input  logic            m1s_ex,
    input  logic            m1s_bd,         // Faulting instruction sits in a delay slot
    input  exc_type_t       m1s_exc_type,
    input  exc_code_t       exc_code,
    input  logic [XLEN-1:0] m1s_pc,
    input  logic [XLEN-1:0] m1s_alu_result, // Data address of loads and stores
    input  logic            timer_ti,
    output logic [XLEN-1:0] status,
    output logic [XLEN-1:0] cause,
    output logic [XLEN-1:0] epc,
    output logic [XLEN-1:0] badvaddr,
    output logic            status_ie,
    output logic            status_exl,
    output logic [IM_W-1:0] status_im,
    output logic [IM_W-1:0] cause_ip,
    output logic            cause_ti
);

    logic            cu0, bev, um, erl, exl, ie;
    logic [IM_W-1:0] im;
    logic [XLEN-1:0] status_wr;   // Write data with read-only bits cleared
    logic            bd;
    logic            ip7;         // Timer line, TI delayed one clock
    logic [1:0]      ip_sw;       // Software interrupts IP1..IP0
    exc_code_t       exc_code_q;
    logic            first_exc;   // Exception taken outside a handler

    assign status_wr = wdata & STATUS_WMASK;
    assign first_exc = m1s_ex && !exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            cu0 <= STATUS_RESET[28];
            bev <= STATUS_RESET[22];
            im  <= STATUS_RESET[15:8];
            um  <= STATUS_RESET[4];
            erl <= STATUS_RESET[2];
            ie  <= STATUS_RESET[0];
        end else if (status_we) begin
            cu0 <= status_wr[28];
            bev <= status_wr[22];
            im  <= status_wr[15:8];
            um  <= status_wr[4];
            erl <= status_wr[2];
            ie  <= status_wr[0];
        end
    end

    // EXL priority: exception, then eret, then mtc0
    always_ff @(posedge clk) begin
        if (reset) exl <= STATUS_RESET[1];
        else if (m1s_ex) exl <= 1'b1;
        else if (eret_flush) exl <= 1'b0;
        else if (status_we) exl <= status_wr[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd         <= 1'b0;
            ip7        <= 1'b0;
            ip_sw      <= 2'b0;
            exc_code_q <= CODE_INT;
        end else begin
            ip7 <= timer_ti;
            if (first_exc) bd <= m1s_bd;  // Nested exception keeps the first BD
            if (m1s_ex) exc_code_q <= exc_code;
            if (cause_we) ip_sw <= wdata[9:8];
        end
    end

    // EPC points at the branch when the fault is in its delay slot
    always_ff @(posedge clk) begin
        if (first_exc) epc <= m1s_bd ? m1s_pc - 32'd4 : m1s_pc;
        else if (epc_we) epc <= wdata;
    end

    always_ff @(posedge clk) begin
        if (m1s_ex && m1s_exc_type == EXC_ADES) begin
            badvaddr <= m1s_alu_result;
        end else if (m1s_ex && m1s_exc_type == EXC_ADEL) begin
            badvaddr <= (|m1s_pc[1:0]) ? m1s_pc : m1s_alu_result;  // Fetch or load fault
        end
    end

    assign status = {3'b0, cu0, 5'b0, bev, 6'b0, im, 3'b0, um, 1'b0, erl, exl, ie};
    assign cause  = {bd, timer_ti, 14'b0, cause_ip, 1'b0, exc_code_q, 2'b0};

    assign status_ie  = ie;
    assign status_exl = exl;
    assign status_im  = im;
    assign cause_ip   = {ip7, 5'b0, ip_sw};  // No external lines
    assign cause_ti   = timer_ti;

    // eret is squashed by a same-slot exception upstream
    assert property (@(posedge clk) disable iff (reset) !(eret_flush && m1s_ex))
        else $error("cp0_exc_regs: eret flush together with an exception");

endmodule

/* hdl/cp0_pkg.sv */
package cp0_pkg;

    localparam int XLEN   = 32;  // Data path width
    localparam int IM_W   = 8;   // Interrupt mask and pending field width
    localparam int CODE_W = 5;   // ExcCode width

    // Register address, rd in the upper five bits, sel in the lower three
    typedef logic [7:0] cp0_addr_t;

    localparam cp0_addr_t ADDR_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t ADDR_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t ADDR_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t ADDR_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t ADDR_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t ADDR_EPC      = {5'd14, 3'd0};

    // Exception types as the pipeline reports them
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd1,   // Address error on load or fetch
        EXC_ADES = 5'd2,   // Address error on store
        EXC_SYS  = 5'd3,
        EXC_BP   = 5'd4,
        EXC_RI   = 5'd5,   // Reserved instruction
        EXC_OV   = 5'd6
    } exc_type_t;

    // Architectural ExcCode
    typedef logic [CODE_W-1:0] exc_code_t;

    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_OV   = 5'd12;

    // Writable Status bits: CU0, BEV, IM, UM, ERL, EXL, IE
    localparam logic [XLEN-1:0] STATUS_WMASK = 32'h1040_ff17;

    // Only BEV set out of reset
    localparam logic [XLEN-1:0] STATUS_RESET = 32'h0040_0000;

endpackage

/* hdl/cp0_read_mux.sv */
`timescale 1ns/1ns

module cp0_read_mux import cp0_pkg::*; (
    input  cp0_addr_t       addr,      // {rd, sel} of the mfc0
    input  logic [XLEN-1:0] count,
    input  logic [XLEN-1:0] compare,
    input  logic [XLEN-1:0] status,
    input  logic [XLEN-1:0] cause,
    input  logic [XLEN-1:0] epc,
    input  logic [XLEN-1:0] badvaddr,
    output logic [XLEN-1:0] rdata
);

    // Combinational read, same cycle as the address
    always_comb begin
        case (addr)
            ADDR_BADVADDR: rdata = badvaddr;
            ADDR_COUNT:    rdata = count;
            ADDR_COMPARE:  rdata = compare;
            ADDR_STATUS:   rdata = status;
            ADDR_CAUSE:    rdata = cause;
            ADDR_EPC:      rdata = epc;
            // TLB registers and anything else unmapped
            default:       rdata = '0;
        endcase
    end

endmodule

/* hdl/cp0_timer.sv */
`timescale 1ns/1ns

module cp0_timer import cp0_pkg::*; #(
    parameter logic [XLEN-1:0] COMPARE_INIT = 32'h0001_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            count_we,
    input  logic            compare_we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] count,
    output logic [XLEN-1:0] compare,
    output logic            timer_ti
);

    logic tick;   // Count steps when high, toggles every clock
    logic match;  // Count equals Compare

    assign match = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;  // Phase free running, writes leave it alone
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count_we) begin
            count <= wdata;  // Software write wins over the step
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare  <= COMPARE_INIT;
            timer_ti <= 1'b0;
        end else begin
            if (compare_we) begin
                compare <= wdata;
            end
            // Compare write acknowledges the interrupt
            if (compare_we) timer_ti <= 1'b0;
            else if (match) timer_ti <= 1'b1;
        end
    end

    // TI only comes up from a match that was not overridden by a Compare write
    assert property (@(posedge clk) disable iff (reset)
        $rose(timer_ti) |-> $past(match && !compare_we))
        else $error("cp0_timer: TI rose without a Count/Compare match");

endmodule

/* hdl/cp0_top.sv */
`timescale 1ns/1ns

module cp0_top import cp0_pkg::*; #(
    parameter logic [XLEN-1:0] COMPARE_INIT = 32'h0001_0000  // Compare after reset
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            m1s_valid,
    input  logic            m1s_inst_mtc0,
    input  logic            m1s_inst_eret,
    input  logic            m1s_ex,
    input  logic            m1s_bd,
    input  logic [4:0]      m1s_rd,
    input  logic [2:0]      m1s_sel,
    input  exc_type_t       m1s_exc_type,
    input  logic [XLEN-1:0] m1s_result,     // mtc0 write data
    input  logic [XLEN-1:0] m1s_alu_result,
    input  logic [XLEN-1:0] m1s_pc,
    output logic [XLEN-1:0] rdata,
    output logic            eret_flush,
    output logic [XLEN-1:0] epc,
    output logic            status_ie,
    output logic            status_exl,
    output logic [IM_W-1:0] status_im,
    output logic [IM_W-1:0] cause_ip,
    output logic            cause_ti
);

    cp0_addr_t       addr;
    logic            count_we, compare_we, status_we, cause_we, epc_we;
    exc_code_t       exc_code;
    logic            timer_ti;
    logic [XLEN-1:0] count, compare;
    logic [XLEN-1:0] status, cause, badvaddr;  // Images for mfc0

    cp0_cmd_decode i_decode (
        .m1s_valid     (m1s_valid),
        .m1s_inst_mtc0 (m1s_inst_mtc0),
        .m1s_inst_eret (m1s_inst_eret),
        .m1s_ex        (m1s_ex),
        .m1s_rd        (m1s_rd),
        .m1s_sel       (m1s_sel),
        .m1s_exc_type  (m1s_exc_type),
        .addr          (addr),
        .count_we      (count_we),
        .compare_we    (compare_we),
        .status_we     (status_we),
        .cause_we      (cause_we),
        .epc_we        (epc_we),
        .eret_flush    (eret_flush),
        .exc_code      (exc_code)
    );

    cp0_timer #(.COMPARE_INIT(COMPARE_INIT)) i_timer (
        .clk        (clk),
        .reset      (reset),
        .count_we   (count_we),
        .compare_we (compare_we),
        .wdata      (m1s_result),
        .count      (count),
        .compare    (compare),
        .timer_ti   (timer_ti)
    );

    cp0_exc_regs i_exc_regs (
        .clk            (clk),
        .reset          (reset),
        .status_we      (status_we),
        .cause_we       (cause_we),
        .epc_we         (epc_we),
        .eret_flush     (eret_flush),
        .wdata          (m1s_result),
        .m1s_ex         (m1s_ex),
        .m1s_bd         (m1s_bd),
        .m1s_exc_type   (m1s_exc_type),
        .exc_code       (exc_code),
        .m1s_pc         (m1s_pc),
        .m1s_alu_result (m1s_alu_result),
        .timer_ti       (timer_ti),
        .status         (status),
        .cause          (cause),
        .epc            (epc),
        .badvaddr       (badvaddr),
        .status_ie      (status_ie),
        .status_exl     (status_exl),
        .status_im      (status_im),
        .cause_ip       (cause_ip),
        .cause_ti       (cause_ti)
    );

    cp0_read_mux i_read_mux (
        .addr     (addr),
        .count    (count),
        .compare  (compare),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badvaddr (badvaddr),
        .rdata    (rdata)
    );

endmodule

/* verif/cp0_checker.sv */
`timescale 1ns/1ns

module cp0_checker import cp0_pkg::*; (
    input  logic            clk,
    input  logic            eq_en,       // rdata must equal check_exp
    input  logic            min_en,      // rdata must be at least check_exp
    input  logic            ctl_en,      // Control outputs must equal check_exp
    input  logic [XLEN-1:0] check_exp,
    input  logic [127:0]    test_name,   // Up to 16 characters
    input  logic [4:0]      m1s_rd,      // Address of the current mfc0
    input  logic [2:0]      m1s_sel,
    input  logic [XLEN-1:0] rdata,
    input  logic [XLEN-1:0] epc,
    input  logic            eret_flush,
    input  logic            status_ie,
    input  logic            status_exl,
    input  logic [IM_W-1:0] status_im,
    input  logic [IM_W-1:0] cause_ip,
    input  logic            cause_ti,
    output int              errors,
    output int              checks
);

    int              err_count = 0;
    int              chk_count = 0;
    logic [XLEN-1:0] ctl;      // Control outputs packed into one word
    logic [XLEN-1:0] actual;

    assign ctl = {12'b0, eret_flush, status_ie, status_exl, cause_ti, status_im, cause_ip};
    assign actual = ctl_en ? ctl : rdata;

    assign errors = err_count;
    assign checks = chk_count;

    // Mid cycle, inputs settled since the 2 ns drive
    always @(negedge clk) begin
        if (eq_en || ctl_en) begin
            chk_count++;
            if (actual !== check_exp) begin
                err_count++;
                $display("ERR %0s: expected 0x%08h, actual 0x%08h",
                         test_name, check_exp, actual);
            end
        end
        // EPC port carries the same value as an EPC read
        if (eq_en && {m1s_rd, m1s_sel} == ADDR_EPC) begin
            chk_count++;
            if (epc !== check_exp) begin
                err_count++;
                $display("ERR %0s epc port: expected 0x%08h, actual 0x%08h",
                         test_name, check_exp, epc);
            end
        end
        if (min_en) begin
            chk_count++;
            if ($isunknown(rdata) || rdata < check_exp) begin
                err_count++;
                $display("ERR %0s: expected at least 0x%08h, actual 0x%08h",
                         test_name, check_exp, rdata);
            end
        end
    end

endmodule

/* verif/tb_cp0.sv */
`timescale 1ns/1ns

module tb_cp0 import cp0_pkg::*; ();

    localparam logic [XLEN-1:0] COMPARE_PARK = 32'hffff_0000;  // Far beyond the run length
    localparam logic [XLEN-1:0] TIMER_N      = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_TI_BIT = 32'h4000_0000;
    localparam logic [XLEN-1:0] CAUSE_IP7    = 32'h0000_8000;
    localparam int              TI_TIMEOUT   = 100;            // Cycles

    logic clk = 1'b0;
    logic reset;
    logic m1s_valid, m1s_inst_mtc0, m1s_inst_eret, m1s_ex, m1s_bd;
    logic [4:0] m1s_rd;
    logic [2:0] m1s_sel;
    exc_type_t m1s_exc_type;
    logic [XLEN-1:0] m1s_result, m1s_alu_result, m1s_pc;
    logic [XLEN-1:0] rdata, epc;
    logic eret_flush, status_ie, status_exl, cause_ti;
    logic [IM_W-1:0] status_im, cause_ip;
    logic eq_en, min_en, ctl_en;
    logic [XLEN-1:0] check_exp;
    logic [127:0] test_name;
    int errors, checks;
    int timeouts = 0;

    // Shadow registers, TI and IP7 kept out of m_cause
    logic [XLEN-1:0] m_status = STATUS_RESET;
    logic [XLEN-1:0] m_cause = '0;
    logic [XLEN-1:0] m_epc = '0;
    logic [XLEN-1:0] m_badvaddr = '0;

    always #10 clk = ~clk;

    cp0_top #(.COMPARE_INIT(COMPARE_PARK)) i_dut (.*);

    cp0_checker i_chk (.*);

    // Next state of the shadow after one clock with these inputs
    function automatic void cp0_model(input logic valid, mtc0, eret, ex, bd,
            input cp0_addr_t addr, input exc_type_t etype,
            input logic [XLEN-1:0] wdata, alu, pc);
        logic we;
        logic exl_before;
        we = valid && mtc0 && !ex;
        exl_before = m_status[1];
        if (we && addr == ADDR_STATUS) m_status = wdata & STATUS_WMASK;
        if (we && addr == ADDR_CAUSE) m_cause[9:8] = wdata[9:8];  // IP1..IP0 only
        if (we && addr == ADDR_EPC) m_epc = wdata;
        if (ex) begin
            m_status[1] = 1'b1;
            case (etype)
                EXC_ADEL: m_cause[6:2] = CODE_ADEL;
                EXC_ADES: m_cause[6:2] = CODE_ADES;
                EXC_SYS:  m_cause[6:2] = CODE_SYS;
                EXC_BP:   m_cause[6:2] = CODE_BP;
                EXC_RI:   m_cause[6:2] = CODE_RI;
                EXC_OV:   m_cause[6:2] = CODE_OV;
                default:  m_cause[6:2] = CODE_INT;
            endcase
            if (!exl_before) begin
                m_cause[31] = bd;
                m_epc = bd ? pc - 32'd4 : pc;  // Branch address for a delay slot
            end
            if (etype == EXC_ADES) m_badvaddr = alu;
            if (etype == EXC_ADEL) m_badvaddr = (pc[1:0] != 2'b0) ? pc : alu;
        end else if (valid && eret) begin
            m_status[1] = 1'b0;
        end
    endfunction

    // Expected control outputs in the current cycle
    function automatic logic [XLEN-1:0] ctl_expect(input logic eret, ti, ip7);
        return {12'b0, eret, m_status[0], m_status[1], ti, m_status[15:8],
                ip7, 5'b0, m_cause[9:8]};
    endfunction

    task automatic drive_op(input logic valid, mtc0, eret, ex, bd,
            input cp0_addr_t addr, input exc_type_t etype,
            input logic [XLEN-1:0] wdata, alu, pc);
        @(posedge clk);
        #2;
        {eq_en, min_en, ctl_en} = 3'b000;
        m1s_valid      = valid;
        m1s_inst_mtc0  = mtc0;
        m1s_inst_eret  = eret;
        m1s_ex         = ex;
        m1s_bd         = bd;
        {m1s_rd, m1s_sel} = addr;
        m1s_exc_type   = etype;
        m1s_result     = wdata;
        m1s_alu_result = alu;
        m1s_pc         = pc;
        cp0_model(valid, mtc0, eret, ex, bd, addr, etype, wdata, alu, pc);
    endtask

    task automatic set_check(input logic eq, mn, ctl, input logic [XLEN-1:0] exp,
            input logic [127:0] name);
        check_exp = exp;
        test_name = name;
        {eq_en, min_en, ctl_en} = {eq, mn, ctl};
    endtask

    task automatic write_reg(input cp0_addr_t addr, input logic [XLEN-1:0] data);
        drive_op(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, addr, EXC_INT, data, '0, '0);
    endtask

    task automatic take_exc(input exc_type_t etype, input logic bd,
            input logic [XLEN-1:0] pc, alu);
        drive_op(1'b1, 1'b0, 1'b0, 1'b1, bd, '0, etype, '0, alu, pc);
    endtask

    // Idle cycle with the mfc0 address on rd and sel
    task automatic read_reg(input logic [127:0] name, input cp0_addr_t addr,
            input logic [XLEN-1:0] exp, input logic at_least);
        drive_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, addr, EXC_INT, '0, '0, '0);
        set_check(!at_least, at_least, 1'b0, exp, name);
    endtask

    task automatic read_ctl(input logic [127:0] name, input logic [XLEN-1:0] exp);
        drive_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, EXC_INT, '0, '0, '0);
        set_check(1'b0, 1'b0, 1'b1, exp, name);
    endtask

    initial begin
        logic [XLEN-1:0] val;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] eret_exp;
        logic            got_ti;
        void'($urandom(36526));
        reset = 1'b1;
        {m1s_valid, m1s_inst_mtc0, m1s_inst_eret, m1s_ex, m1s_bd} = 5'b0;
        {m1s_rd, m1s_sel} = '0;
        m1s_exc_type = EXC_INT;
        {m1s_result, m1s_alu_result, m1s_pc} = '0;
        {eq_en, min_en, ctl_en} = 3'b000;
        check_exp = '0;
        test_name = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        read_reg("reset_status", ADDR_STATUS, STATUS_RESET, 1'b0);
        read_reg("reset_cause", ADDR_CAUSE, '0, 1'b0);
        read_ctl("reset_ctl", ctl_expect(1'b0, 1'b0, 1'b0));

        for (int i = 0; i < 6; i++) begin
            write_reg(ADDR_STATUS, $urandom);
            read_reg("status_write", ADDR_STATUS, m_status, 1'b0);
            write_reg(ADDR_CAUSE, $urandom);
            read_reg("cause_write", ADDR_CAUSE, m_cause, 1'b0);
            write_reg(ADDR_EPC, $urandom);
            read_reg("epc_write", ADDR_EPC, m_epc, 1'b0);
        end
        drive_op(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, ADDR_EPC, EXC_INT, $urandom, '0, '0);
        read_reg("epc_no_valid", ADDR_EPC, m_epc, 1'b0);
        drive_op(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, ADDR_STATUS, EXC_SYS, 32'h0, '0, 32'h400);
        read_reg("status_ex_write", ADDR_STATUS, m_status, 1'b0);

        write_reg(ADDR_STATUS, 32'h0000_ff01);  // IE and IM on, EXL clear
        val = $urandom;
        pc = $urandom & ~32'h3;
        take_exc(EXC_SYS, val[0], pc, '0);
        read_reg("exc1_status", ADDR_STATUS, m_status, 1'b0);
        read_reg("exc1_epc", ADDR_EPC, m_epc, 1'b0);
        read_reg("exc1_cause", ADDR_CAUSE, m_cause, 1'b0);
        take_exc(EXC_OV, !val[0], pc + 32'h100, '0);  // Nested, EXL already set
        read_reg("exc2_epc", ADDR_EPC, m_epc, 1'b0);
        read_reg("exc2_cause", ADDR_CAUSE, m_cause, 1'b0);
        eret_exp = ctl_expect(1'b1, 1'b0, 1'b0);  // Flush seen before EXL drops
        drive_op(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, '0, EXC_INT, '0, '0, '0);
        set_check(1'b0, 1'b0, 1'b1, eret_exp, "eret_flush");
        read_reg("eret_status", ADDR_STATUS, m_status, 1'b0);

        take_exc(EXC_ADES, 1'b0, pc, $urandom);
        read_reg("ades_addr", ADDR_BADVADDR, m_badvaddr, 1'b0);
        take_exc(EXC_ADEL, 1'b0, pc | 32'h2, $urandom);  // Misaligned fetch
        read_reg("adel_pc", ADDR_BADVADDR, m_badvaddr, 1'b0);
        take_exc(EXC_ADEL, 1'b0, pc, $urandom);
        read_reg("adel_addr", ADDR_BADVADDR, m_badvaddr, 1'b0);
        take_exc(EXC_BP, 1'b0, $urandom, $urandom);
        read_reg("badvaddr_keep", ADDR_BADVADDR, m_badvaddr, 1'b0);

        write_reg(ADDR_COUNT, 32'h0);
        write_reg(ADDR_COMPARE, TIMER_N);
        got_ti = 1'b0;
        for (int i = 0; i < TI_TIMEOUT && !got_ti; i++) begin
            drive_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, EXC_INT, '0, '0, '0);
            got_ti = cause_ti;
        end
        if (!got_ti) begin
            timeouts++;
            $display("Timeout: cause_ti did not rise within %0d cycles", TI_TIMEOUT);
        end
        read_reg("count_min", ADDR_COUNT, TIMER_N, 1'b1);
        read_reg("ti_cause", ADDR_CAUSE, m_cause | CAUSE_TI_BIT | CAUSE_IP7, 1'b0);
        read_ctl("ti_ctl", ctl_expect(1'b0, 1'b1, 1'b1));
        write_reg(ADDR_COMPARE, COMPARE_PARK);  // Acknowledges TI
        read_reg("compare_write", ADDR_COMPARE, COMPARE_PARK, 1'b0);
        read_ctl("ti_clear", ctl_expect(1'b0, 1'b0, 1'b0));

        read_reg("index_zero", {5'd0, 3'd0}, '0, 1'b0);
        read_reg("entryhi_zero", {5'd10, 3'd0}, '0, 1'b0);
        read_reg("sel1_zero", {5'd12, 3'd1}, '0, 1'b0);
        drive_op(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, EXC_INT, '0, '0, '0);
        @(posedge clk);

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
